/* logic/peri_map_pkg.sv */
`default_nettype none

// **************************************************************************
// Address map of the peripheral group
// **************************************************************************

package peri_map_pkg;

	// Slot field of the APB address, one slot per peripheral
	localparam int SLOT_MSB = 11;
	localparam int SLOT_LSB = 8;

	// Slot codes
	// Codes not listed here are unmapped and answer with an error
	localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_LOCK = 4'd0;
	localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_AUTO_ID = 4'd1;
	localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_CLOCK = 4'd2;

	// Lowest bit of the lock mask and of the ID select field
	// The field runs from here up to the top of the offset (bit 7),
	// which leaves room for six locks or six counters
	localparam int MASK_LSB = 2;

	// In the clock slot this bit picks the upper word
	localparam int CLOCK_HALF_BIT = 2;

endpackage

`default_nettype wire

/* logic/peri_width_pkg.sv */
`default_nettype none

// **************************************************************************
// Data widths of the peripheral group
// **************************************************************************

package peri_width_pkg;

	// APB data word
	localparam int BW_DATA = 32;

	// Automatic ID counters
	localparam int BW_AUTO_ID = 8;
	localparam logic [BW_AUTO_ID-1:0] MAX_AUTO_ID = 8'd255;

	// Free running real-time clock
	localparam int BW_REAL_CLOCK = 64;

endpackage

`default_nettype wire

/* logic/apb_slot_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

// Splits the APB slave port into slots.
// Each strobe is high only in the access cycle (psel and penable both high)
// of an access that hits its slot

module apb_slot_decoder
#(
	parameter int BW_ADDR = 12
)
(
	input  wire                               i_psel,
	input  wire                               i_penable,
	input  wire  [BW_ADDR-1:0]                i_paddr,
	input  wire                               i_pwrite,

	output logic                              o_lock_access,
	output logic                              o_id_access,
	output logic                              o_clock_access,
	output logic                              o_unmapped_access,
	output logic [peri_map_pkg::SLOT_LSB-1:0] o_offset,
	output logic                              o_write
);

	logic                                                   access_phase;
	logic [peri_map_pkg::SLOT_MSB-peri_map_pkg::SLOT_LSB:0] slot;
	logic                                                   hit_lock;
	logic                                                   hit_id;
	logic                                                   hit_clock;

	// Second cycle of the APB transfer
	assign access_phase = i_psel & i_penable;

	// **********************************************************************
	// Slot match
	// **********************************************************************

	assign slot = i_paddr[peri_map_pkg::SLOT_MSB:peri_map_pkg::SLOT_LSB];

	assign hit_lock  = (slot == peri_map_pkg::SLOT_LOCK);
	assign hit_id    = (slot == peri_map_pkg::SLOT_AUTO_ID);
	assign hit_clock = (slot == peri_map_pkg::SLOT_CLOCK);

	// Exactly one of these is high in each access cycle
	assign o_lock_access     = access_phase & hit_lock;
	assign o_id_access       = access_phase & hit_id;
	assign o_clock_access    = access_phase & hit_clock;
	assign o_unmapped_access = access_phase & ~(hit_lock | hit_id | hit_clock);

	// **********************************************************************
	// Fields passed on to the banks
	// **********************************************************************

	assign o_offset = i_paddr[peri_map_pkg::SLOT_LSB-1:0];
	assign o_write  = i_pwrite;

endmodule

`default_nettype wire

/* logic/hw_lock_bank.sv */
`timescale 1ns/100ps
`default_nettype none

// Hardware locks for mutual exclusion between cores.
// A read tries to take every lock in the mask, a write gives them back

module hw_lock_bank
#(
	parameter int NUM_LOCK = 6
)
(
	input  wire                                 clk,
	input  wire                                 rstnn,
	input  wire                                 i_access,
	input  wire                                 i_write,
	input  wire  [peri_map_pkg::SLOT_LSB-1:0]   i_offset,

	output logic [peri_width_pkg::BW_DATA-1:0]  o_rdata,
	output logic [NUM_LOCK-1:0]                 o_lock_status
);

	logic [NUM_LOCK-1:0] mask;
	logic [NUM_LOCK-1:0] grant;
	logic [NUM_LOCK-1:0] lock_held;

	// Lock mask sits in the offset above the byte lanes
	assign mask = i_offset[peri_map_pkg::MASK_LSB +: NUM_LOCK];

	// Locks that were free and are taken by this read
	assign grant = mask & ~lock_held;

	assign o_rdata = {{(peri_width_pkg::BW_DATA-NUM_LOCK){1'b0}}, grant};
	assign o_lock_status = lock_held;

	// **********************************************************************
	// Lock state
	// **********************************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			lock_held <= '0;
		end
		else if (i_access)
		begin
			if (i_write)
			begin
				// Release
				lock_held <= lock_held & ~mask;
			end
			else
			begin
				// Acquire, a held lock simply stays held
				lock_held <= lock_held | mask;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/auto_id_bank.sv */
`timescale 1ns/100ps
`default_nettype none

// Bank of ID counters that hand out increasing numbers.
// A read returns the selected counters and moves them on by one,
// a write clears the selected counters

module auto_id_bank
#(
	parameter int NUM_AUTO_ID = 4
)
(
	input  wire                                 clk,
	input  wire                                 rstnn,
	input  wire                                 i_access,
	input  wire                                 i_write,
	input  wire  [peri_map_pkg::SLOT_LSB-1:0]   i_offset,

	output logic [peri_width_pkg::BW_DATA-1:0]  o_rdata
);

	logic [NUM_AUTO_ID-1:0]                select;
	logic [peri_width_pkg::BW_AUTO_ID-1:0] id_count [NUM_AUTO_ID];
	logic [peri_width_pkg::BW_AUTO_ID-1:0] id_merged;

	assign select = i_offset[peri_map_pkg::MASK_LSB +: NUM_AUTO_ID];

	// OR of every selected counter
	always_comb
	begin
		id_merged = '0;
		for (int i = 0; i < NUM_AUTO_ID; i++)
		begin
			if (select[i])
				id_merged = id_merged | id_count[i];
		end
	end

	assign o_rdata = {{(peri_width_pkg::BW_DATA-peri_width_pkg::BW_AUTO_ID){1'b0}}, id_merged};

	// **********************************************************************
	// Counters
	// **********************************************************************

	for (genvar g = 0; g < NUM_AUTO_ID; g++)
	begin : g_counter
		always_ff @(posedge clk or negedge rstnn)
		begin
			if (!rstnn)
			begin
				id_count[g] <= '0;
			end
			else if (i_access && select[g])
			begin
				if (i_write)
					id_count[g] <= '0;
				else if (id_count[g] != peri_width_pkg::MAX_AUTO_ID)
					id_count[g] <= id_count[g] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/clock_snapshot.sv */
`timescale 1ns/100ps
`default_nettype none

// Lets a 32-bit bus read the 64-bit real clock as one coherent value.
// The first access returns the live clock and keeps a copy,
// the second access returns the copy

module clock_snapshot
(
	input  wire                                       clk,
	input  wire                                       rstnn,
	input  wire                                       i_access,
	input  wire                                       i_write,
	input  wire  [peri_map_pkg::SLOT_LSB-1:0]         i_offset,
	input  wire  [peri_width_pkg::BW_REAL_CLOCK-1:0]  i_real_clock,

	output logic [peri_width_pkg::BW_DATA-1:0]        o_rdata,
	output logic                                      o_err
);

	localparam logic PHASE_LIVE    = 1'b0;
	localparam logic PHASE_LATCHED = 1'b1;

	logic                                     phase;
	logic [peri_width_pkg::BW_REAL_CLOCK-1:0] latched_clock;
	logic [peri_width_pkg::BW_REAL_CLOCK-1:0] view_clock;

	assign view_clock = (phase == PHASE_LIVE) ? i_real_clock : latched_clock;

	// Upper or lower half of the clock
	assign o_rdata = i_offset[peri_map_pkg::CLOCK_HALF_BIT] ?
		view_clock[peri_width_pkg::BW_REAL_CLOCK-1 -: peri_width_pkg::BW_DATA] :
		view_clock[peri_width_pkg::BW_DATA-1:0];

	// Clock is read only
	assign o_err = i_access & i_write;

	// Any access flips the phase, writes included
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			phase <= PHASE_LIVE;
		else if (i_access)
			phase <= (phase == PHASE_LIVE) ? PHASE_LATCHED : PHASE_LIVE;
	end

	always_ff @(posedge clk)
	begin
		if (i_access && (phase == PHASE_LIVE))
			latched_clock <= i_real_clock;
	end

endmodule

`default_nettype wire

/* logic/apb_response_merge.sv */
`timescale 1ns/100ps
`default_nettype none

// Picks the response of the addressed slot and forms ready and error

module apb_response_merge
(
	input  wire                                 i_lock_access,
	input  wire                                 i_id_access,
	input  wire                                 i_clock_access,
	input  wire                                 i_unmapped_access,
	input  wire  [peri_width_pkg::BW_DATA-1:0]  i_lock_rdata,
	input  wire  [peri_width_pkg::BW_DATA-1:0]  i_id_rdata,
	input  wire  [peri_width_pkg::BW_DATA-1:0]  i_clock_rdata,
	input  wire                                 i_clock_err,

	output logic [peri_width_pkg::BW_DATA-1:0]  o_prdata,
	output logic                                o_pready,
	output logic                                o_pslverr
);

	// One-hot AND-OR select, unmapped slots read as all ones
	assign o_prdata = ({peri_width_pkg::BW_DATA{i_lock_access}}     & i_lock_rdata)
	                | ({peri_width_pkg::BW_DATA{i_id_access}}       & i_id_rdata)
	                | ({peri_width_pkg::BW_DATA{i_clock_access}}    & i_clock_rdata)
	                | {peri_width_pkg::BW_DATA{i_unmapped_access}};

	// Zero wait, every access completes in its first access cycle
	assign o_pready = i_lock_access | i_id_access | i_clock_access | i_unmapped_access;

	// Locks and IDs never fail
	assign o_pslverr = i_unmapped_access | (i_clock_access & i_clock_err);

endmodule

`default_nettype wire

/* logic/common_peri_group.sv */
`timescale 1ns/100ps
`default_nettype none

// **************************************************************************
// Common peripheral group on one APB slave port
// **************************************************************************

module common_peri_group
#(
	parameter int BW_ADDR     = 12,
	// Both counts are limited to 6 by the mask field width
	parameter int NUM_LOCK    = 6,
	parameter int NUM_AUTO_ID = 4
)
(
	input  wire                                       clk,
	input  wire                                       rstnn,

	input  wire                                       i_psel,
	input  wire                                       i_penable,
	input  wire  [BW_ADDR-1:0]                        i_paddr,
	input  wire                                       i_pwrite,
	input  wire  [peri_width_pkg::BW_DATA-1:0]        i_pwdata,
	output logic [peri_width_pkg::BW_DATA-1:0]        o_prdata,
	output logic                                      o_pready,
	output logic                                      o_pslverr,

	input  wire  [peri_width_pkg::BW_REAL_CLOCK-1:0]  i_real_clock,
	output logic [NUM_LOCK-1:0]                       o_lock_status
);

	logic                                lock_access;
	logic                                id_access;
	logic                                clock_access;
	logic                                unmapped_access;
	logic [peri_map_pkg::SLOT_LSB-1:0]   offset;
	logic                                write;
	logic [peri_width_pkg::BW_DATA-1:0]  lock_rdata;
	logic [peri_width_pkg::BW_DATA-1:0]  id_rdata;
	logic [peri_width_pkg::BW_DATA-1:0]  clock_rdata;
	logic                                clock_err;

	// Decode
	apb_slot_decoder #(
		.BW_ADDR(BW_ADDR)
	) u_decoder (
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_paddr(i_paddr),
		.i_pwrite(i_pwrite),
		.o_lock_access(lock_access),
		.o_id_access(id_access),
		.o_clock_access(clock_access),
		.o_unmapped_access(unmapped_access),
		.o_offset(offset),
		.o_write(write)
	);

	// Execute, the banks take their operands from the address alone
	hw_lock_bank #(
		.NUM_LOCK(NUM_LOCK)
	) u_lock (
		.clk(clk),
		.rstnn(rstnn),
		.i_access(lock_access),
		.i_write(write),
		.i_offset(offset),
		.o_rdata(lock_rdata),
		.o_lock_status(o_lock_status)
	);

	auto_id_bank #(
		.NUM_AUTO_ID(NUM_AUTO_ID)
	) u_auto_id (
		.clk(clk),
		.rstnn(rstnn),
		.i_access(id_access),
		.i_write(write),
		.i_offset(offset),
		.o_rdata(id_rdata)
	);

	clock_snapshot u_clock (
		.clk(clk),
		.rstnn(rstnn),
		.i_access(clock_access),
		.i_write(write),
		.i_offset(offset),
		.i_real_clock(i_real_clock),
		.o_rdata(clock_rdata),
		.o_err(clock_err)
	);

	// Result
	apb_response_merge u_merge (
		.i_lock_access(lock_access),
		.i_id_access(id_access),
		.i_clock_access(clock_access),
		.i_unmapped_access(unmapped_access),
		.i_lock_rdata(lock_rdata),
		.i_id_rdata(id_rdata),
		.i_clock_rdata(clock_rdata),
		.i_clock_err(clock_err),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr)
	);

endmodule

`default_nettype wire

/* verification/peri_group_chk.sv */
`timescale 1ns/100ps
`default_nettype none

// APB response rules of the peripheral group

module peri_group_chk
(
	input  wire  clk,
	input  wire  rstnn,
	input  wire  i_psel,
	input  wire  i_penable,
	input  wire  i_pready,
	input  wire  i_pslverr
);

	// Zero wait slave, ready in every access cycle
	a_ready_in_access: assert property (
		@(posedge clk) disable iff (!rstnn)
		(i_psel && i_penable) |-> i_pready
	) else $error("pready low in an APB access cycle");

	a_err_only_in_access: assert property (
		@(posedge clk) disable iff (!rstnn)
		i_pslverr |-> (i_psel && i_penable)
	) else $error("pslverr high outside an APB access cycle");

endmodule

bind common_peri_group peri_group_chk u_chk (
	.clk(clk),
	.rstnn(rstnn),
	.i_psel(i_psel),
	.i_penable(i_penable),
	.i_pready(o_pready),
	.i_pslverr(o_pslverr)
);

`default_nettype wire

/* verification/peri_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

// Reference model of the group, checks every completed APB access

module peri_monitor
#(
	parameter int NUM_LOCK    = 6,
	parameter int NUM_AUTO_ID = 4
)
(
	input  wire          clk,
	input  wire          rstnn,
	input  wire          i_psel,
	input  wire          i_penable,
	input  wire  [11:0]  i_paddr,
	input  wire          i_pwrite,
	input  wire  [31:0]  i_prdata,
	input  wire          i_pready,
	input  wire          i_pslverr,
	input  wire  [63:0]  i_real_clock,
	input  wire  [NUM_LOCK-1:0] i_lock_status,
	output int           o_check_count,
	output int           o_error_count
);

	logic [NUM_LOCK-1:0] model_lock;
	logic [7:0]          model_id [NUM_AUTO_ID];
	logic                model_latched_phase;
	logic [63:0]         model_snapshot;
	int                  check_count = 0;
	int                  error_count = 0;

	assign o_check_count = check_count;
	assign o_error_count = error_count;

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR @ %0t: %s", $time, msg);
	endtask

	// **********************************************************************
	// Expected response of one access, then the model update
	// **********************************************************************

	task automatic check_access();
		logic [3:0]  slot;
		logic [5:0]  field;
		logic [7:0]  merged;
		logic [63:0] view;
		logic [31:0] exp_data;
		logic        exp_err;
		slot = i_paddr[peri_map_pkg::SLOT_MSB:peri_map_pkg::SLOT_LSB];
		field = i_paddr[7:peri_map_pkg::MASK_LSB];
		exp_data = '0;
		exp_err = 1'b0;
		if (slot == peri_map_pkg::SLOT_LOCK)
		begin
			exp_data[NUM_LOCK-1:0] = field[NUM_LOCK-1:0] & ~model_lock;
			if (i_pwrite)
				model_lock = model_lock & ~field[NUM_LOCK-1:0];
			else
				model_lock = model_lock | field[NUM_LOCK-1:0];
		end
		else if (slot == peri_map_pkg::SLOT_AUTO_ID)
		begin
			merged = '0;
			for (int i = 0; i < NUM_AUTO_ID; i++)
			begin
				if (field[i])
				begin
					merged = merged | model_id[i];
					if (i_pwrite)
						model_id[i] = '0;
					else if (model_id[i] != peri_width_pkg::MAX_AUTO_ID)
						model_id[i] = model_id[i] + 8'd1;
				end
			end
			exp_data[7:0] = merged;
		end
		else if (slot == peri_map_pkg::SLOT_CLOCK)
		begin
			view = model_latched_phase ? model_snapshot : i_real_clock;
			if (!model_latched_phase)
				model_snapshot = i_real_clock;
			model_latched_phase = ~model_latched_phase;
			exp_data = i_paddr[peri_map_pkg::CLOCK_HALF_BIT] ? view[63:32] : view[31:0];
			exp_err = i_pwrite;
		end
		else
		begin
			exp_data = '1;
			exp_err = 1'b1;
		end
		check_count++;
		if (!i_pwrite && i_prdata !== exp_data)
			report_error($sformatf("read of addr %h gave %h, expected %h",
				i_paddr, i_prdata, exp_data));
		if (i_pslverr !== exp_err)
			report_error($sformatf("pslverr %b at addr %h, expected %b",
				i_pslverr, i_paddr, exp_err));
	endtask

	// Sampled mid cycle, the stimulus moves just after the rising edge
	always @(negedge clk)
	begin
		if (!rstnn)
		begin
			model_lock = '0;
			model_latched_phase = 1'b0;
			for (int i = 0; i < NUM_AUTO_ID; i++)
				model_id[i] = '0;
		end
		else
		begin
			if (i_lock_status !== model_lock)
				report_error($sformatf("lock status %b, expected %b", i_lock_status, model_lock));
			if (i_pslverr && !(i_psel && i_penable))
				report_error("pslverr high outside an access cycle");
			if (i_psel && i_penable && !i_pready)
				report_error("pready low in an access cycle");
			else if (i_psel && i_penable)
				check_access();
		end
	end

endmodule

`default_nettype wire

/* verification/tb_common_peri_group.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_common_peri_group;

	localparam int NUM_LOCK = 6;
	localparam int NUM_AUTO_ID = 4;
	localparam int ID_SAT_READS = 258;
	// Accesses of tests 1 to 5, each access takes at most 3 cycles
	localparam int TOTAL_ACCESS = 6 + (ID_SAT_READS + 9) + 8 + 9 + 400;
	localparam int WATCHDOG_CYCLES = TOTAL_ACCESS * 3 + 100;

	logic                clk = 1'b0;
	logic                rstnn;
	logic                psel;
	logic                penable;
	logic [11:0]         paddr;
	logic                pwrite;
	logic [31:0]         pwdata;
	logic [31:0]         prdata;
	logic                pready;
	logic                pslverr;
	logic [63:0]         real_clock;
	logic [NUM_LOCK-1:0] lock_status;
	logic [31:0]         lcg_state = 32'd76;
	int                  check_count;
	int                  error_count;
	int                  mark_checks = 0;
	int                  mark_errors = 0;

	always #10 clk = ~clk;

	common_peri_group #(
		.BW_ADDR(12),
		.NUM_LOCK(NUM_LOCK),
		.NUM_AUTO_ID(NUM_AUTO_ID)
	) dut (
		.clk(clk), .rstnn(rstnn),
		.i_psel(psel), .i_penable(penable), .i_paddr(paddr),
		.i_pwrite(pwrite), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.i_real_clock(real_clock), .o_lock_status(lock_status)
	);

	peri_monitor #(
		.NUM_LOCK(NUM_LOCK),
		.NUM_AUTO_ID(NUM_AUTO_ID)
	) u_monitor (
		.clk(clk), .rstnn(rstnn),
		.i_psel(psel), .i_penable(penable), .i_paddr(paddr), .i_pwrite(pwrite),
		.i_prdata(prdata), .i_pready(pready), .i_pslverr(pslverr),
		.i_real_clock(real_clock), .i_lock_status(lock_status),
		.o_check_count(check_count), .o_error_count(error_count)
	);

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// One cycle, the real clock jumps by a random step
	task automatic tick();
		logic [31:0] r;
		@(posedge clk);
		#2;
		r = next_rand();
		real_clock = real_clock + {34'd0, r[31:2]};
	endtask

	task automatic apb_access(input logic write, input logic [3:0] slot,
		input logic [7:0] offset);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = {slot, offset};
		pwdata = next_rand();
		tick();
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		tick();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic field_access(input logic write, input logic [3:0] slot,
		input logic [5:0] field);
		apb_access(write, slot, {field, 2'b00});
	endtask

	task automatic clock_read(input logic upper);
		apb_access(1'b0, peri_map_pkg::SLOT_CLOCK, {5'd0, upper, 2'b00});
	endtask

	task automatic end_test(input string name);
		tick();
		tick();
		$display("Test %s: %0d checks, %0d errors, %s", name, check_count - mark_checks,
			error_count - mark_errors, (error_count == mark_errors) ? "passed" : "failed");
		mark_checks = check_count;
		mark_errors = error_count;
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		logic [31:0] r;
		logic [3:0]  slot;
		rstnn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		real_clock = 64'h0000_0003_F000_0000;
		repeat (4) tick();
		rstnn = 1'b1;
		tick();

		field_access(1'b0, peri_map_pkg::SLOT_LOCK, 6'b000011);
		field_access(1'b0, peri_map_pkg::SLOT_LOCK, 6'b000110);
		field_access(1'b0, peri_map_pkg::SLOT_LOCK, 6'b000011);
		field_access(1'b1, peri_map_pkg::SLOT_LOCK, 6'b000001);
		field_access(1'b0, peri_map_pkg::SLOT_LOCK, 6'b111111);
		field_access(1'b1, peri_map_pkg::SLOT_LOCK, 6'b111111);
		end_test("1 lock acquire and release");

		field_access(1'b1, peri_map_pkg::SLOT_AUTO_ID, 6'b001111);
		repeat (ID_SAT_READS) field_access(1'b0, peri_map_pkg::SLOT_AUTO_ID, 6'b000001);
		field_access(1'b1, peri_map_pkg::SLOT_AUTO_ID, 6'b000001);
		repeat (2) field_access(1'b0, peri_map_pkg::SLOT_AUTO_ID, 6'b000001);
		repeat (3) field_access(1'b0, peri_map_pkg::SLOT_AUTO_ID, 6'b000010);
		repeat (2) field_access(1'b0, peri_map_pkg::SLOT_AUTO_ID, 6'b000011);
		end_test("2 auto ID sequence");

		// Lower word latches, upper word comes from the copy
		repeat (4)
		begin
			clock_read(1'b0);
			clock_read(1'b1);
		end
		end_test("3 clock coherence");

		apb_access(1'b0, 4'd3, 8'h00);
		apb_access(1'b1, 4'd9, 8'h10);
		apb_access(1'b0, 4'hF, 8'hFC);
		apb_access(1'b1, peri_map_pkg::SLOT_CLOCK, 8'h00);
		clock_read(1'b1);
		clock_read(1'b0);
		clock_read(1'b1);
		field_access(1'b0, peri_map_pkg::SLOT_LOCK, 6'b000000);
		field_access(1'b0, peri_map_pkg::SLOT_AUTO_ID, 6'b000000);
		end_test("4 error responses");

		for (int n = 0; n < 400; n++)
		begin
			r = next_rand();
			case (r[31:30])
				2'd0: slot = peri_map_pkg::SLOT_LOCK;
				2'd1: slot = peri_map_pkg::SLOT_AUTO_ID;
				2'd2: slot = peri_map_pkg::SLOT_CLOCK;
				default: slot = (r[27:24] < 4'd3) ? r[27:24] + 4'd3 : r[27:24];
			endcase
			// Clock writes kept rare so most clock reads form pairs
			if (slot == peri_map_pkg::SLOT_CLOCK)
				apb_access(r[29] & r[28], slot, r[23:16]);
			else
				apb_access(r[29], slot, r[23:16]);
		end
		end_test("5 random mixed traffic");

		$display("Total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
logic/peri_map_pkg.sv
logic/peri_width_pkg.sv
logic/apb_slot_decoder.sv
logic/hw_lock_bank.sv
logic/auto_id_bank.sv
logic/clock_snapshot.sv
logic/apb_response_merge.sv
logic/common_peri_group.sv
verification/peri_group_chk.sv
verification/peri_monitor.sv
verification/tb_common_peri_group.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing --timescale 1ns/100ps -Mdir obj_dir
TOP       = tb_common_peri_group
FILELIST  = list.f
SIM       = obj_dir/V$(TOP)
RUNFLAGS  = +verilator+error+limit+1000

SOURCES   = $(wildcard logic/*.sv verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
